// ==== rv_pipe_settings.svh ====
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// width of registers, ALU and data bus
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NREGS 32

`endif

// ==== rv_pipe_pkg.sv ====
`include "rv_pipe_settings.svh"

package rv_pipe_pkg;

  // data and address values
  typedef logic [`RV_XLEN-1:0] word_t;

  // register number, wide enough for every architectural register
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  // raw instruction word
  typedef logic [31:0] instr_t;

  // ALU operation select
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;

  // write-back source select
  typedef logic [1:0] res_src_t;

  localparam res_src_t RES_ALU  = 2'd0;
  localparam res_src_t RES_MEM  = 2'd1;
  localparam res_src_t RES_LINK = 2'd2;

endpackage

// ==== rv_pipe_if.sv ====
// stall, flush and enable decisions of the hazard unit
interface hazard_ctrl_if;
  logic pc_en, if_id_en, if_flush, ctrl_zero;
  logic id_ex_en, ex_mem_en, mem_reset;

  modport hazard (output pc_en, if_id_en, if_flush, ctrl_zero, id_ex_en, ex_mem_en, mem_reset);
  modport execute (input id_ex_en);
  modport result (input ex_mem_en, mem_reset);
endinterface

// decoded instruction from ID into the ID/EX register
interface id_ex_if;
  import rv_pipe_pkg::*;

  logic      valid;
  word_t     rs1_val, rs2_val, imm, pc_plus4;
  reg_addr_t rs1, rs2, rd;
  alu_op_t   alu_op;
  logic      use_imm, reg_write, mem_read, mem_write;
  res_src_t  res_src;
  // destination of the instruction now in EX, back to the hazard unit
  reg_addr_t ex_rd;
  logic      ex_reg_write;

  modport decode (
    output valid, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op, use_imm,
    output reg_write, mem_read, mem_write, res_src, pc_plus4,
    input  ex_rd, ex_reg_write
  );
  modport execute (
    input  valid, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op, use_imm,
    input  reg_write, mem_read, mem_write, res_src, pc_plus4,
    output ex_rd, ex_reg_write
  );
endinterface

// EX results into the EX/MEM register, forwarding and write-back paths back
interface ex_mem_if;
  import rv_pipe_pkg::*;

  word_t     alu_result, store_data, pc_plus4;
  reg_addr_t rd;
  logic      reg_write, mem_read, mem_write;
  res_src_t  res_src;
  reg_addr_t mem_rd, wb_rd;
  logic      mem_reg_write, mem_busy, wb_reg_write;
  word_t     mem_fwd_value, wb_value;

  modport execute (
    output alu_result, store_data, rd, reg_write, mem_read, mem_write, res_src, pc_plus4,
    input  mem_rd, mem_reg_write, mem_fwd_value, wb_rd, wb_reg_write, wb_value
  );
  modport result (
    input  alu_result, store_data, rd, reg_write, mem_read, mem_write, res_src, pc_plus4,
    output mem_rd, mem_reg_write, mem_fwd_value, mem_busy, wb_rd, wb_reg_write, wb_value
  );
  modport decode (
    input mem_rd, mem_reg_write, mem_fwd_value, mem_busy, wb_rd, wb_reg_write, wb_value
  );
endinterface

// ==== hazard_detection_unit.sv ====
module hazard_detection_unit (
  input  logic                   mem_busy_i,
  input  logic                   load_in_ex_i,
  input  rv_pipe_pkg::reg_addr_t ex_rd_i,
  input  logic                   ex_reg_write_i,
  input  rv_pipe_pkg::reg_addr_t mem_rd_i,
  input  logic                   mem_reg_write_i,
  input  rv_pipe_pkg::reg_addr_t rs1_i,
  input  rv_pipe_pkg::reg_addr_t rs2_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  input  logic                   jump_i,
  input  logic                   ret_i,
  hazard_ctrl_if.hazard          ctrl_o
);

  logic ex_match;
  logic mem_match;
  logic load_use;
  logic branch_dep;

  // register numbers are compared as they are, x0 is not special here
  assign ex_match  = (rs1_i == ex_rd_i) || (rs2_i == ex_rd_i);
  assign mem_match = (rs1_i == mem_rd_i) || (rs2_i == mem_rd_i);

  assign load_use = load_in_ex_i && ex_match;

  // branches and jalr resolve in ID, so any pending write to a source must land first
  assign branch_dep = (branch_i || ret_i) &&
                      ((ex_match && ex_reg_write_i) || (mem_match && mem_reg_write_i));

  always_comb begin
    ctrl_o.pc_en     = 1'b1;
    ctrl_o.if_id_en  = 1'b1;
    ctrl_o.if_flush  = 1'b0;
    ctrl_o.ctrl_zero = 1'b0;
    ctrl_o.id_ex_en  = 1'b1;
    ctrl_o.ex_mem_en = 1'b1;
    ctrl_o.mem_reset = 1'b0;
    if (mem_busy_i) begin
      // data memory still busy, freeze the pipe and bubble into WB
      ctrl_o.pc_en     = 1'b0;
      ctrl_o.if_id_en  = 1'b0;
      ctrl_o.id_ex_en  = 1'b0;
      ctrl_o.ex_mem_en = 1'b0;
      ctrl_o.mem_reset = 1'b1;
    end else if (load_use || branch_dep) begin
      // hold fetch and decode, send a bubble into EX
      ctrl_o.pc_en     = 1'b0;
      ctrl_o.if_id_en  = 1'b0;
      ctrl_o.ctrl_zero = 1'b1;
    end else if ((branch_i && branch_taken_i) || jump_i || ret_i) begin
      // redirect, the flush turns the wrongly fetched word into a bubble
      ctrl_o.if_flush = 1'b1;
    end
  end

endmodule

// ==== fetch_decode_stage.sv ====
`include "rv_pipe_settings.svh"

module fetch_decode_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output rv_pipe_pkg::word_t  imem_addr_o,
  input  rv_pipe_pkg::instr_t imem_data_i,
  id_ex_if.decode             ex_o,
  ex_mem_if.decode            mem_io,
  hazard_ctrl_if              ctrl_io
);

  import rv_pipe_pkg::*;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam instr_t     NOP       = 32'h0000_0013;

  word_t     pc_q, pc_next, if_pc_q;
  logic      if_valid_q, ex_load_q;
  instr_t    if_instr_q, instr;
  word_t     rf [`RV_NREGS];
  reg_addr_t rs1, rs2, rd;
  word_t     imm, rs1_val, rs2_val;
  logic      is_branch, is_jal, is_jalr, branch_taken;
  logic      writes_rd, mem_read, mem_write, use_imm;
  alu_op_t   alu_op;
  res_src_t  res_src;

  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= `RV_RESET_PC;
    end else if (ctrl_io.pc_en) begin
      pc_q <= pc_next;
    end
  end

  // IF/ID, a flush leaves an invalid slot behind
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      if_valid_q <= 1'b0;
    end else if (ctrl_io.if_id_en) begin
      if_valid_q <= !ctrl_io.if_flush;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_io.if_id_en) begin
      if_instr_q <= imem_data_i;
      if_pc_q    <= pc_q;
    end
  end

  // an empty slot decodes as addi x0, x0, 0
  assign instr = if_valid_q ? if_instr_q : NOP;
  assign rs1   = instr[19:15];
  assign rs2   = instr[24:20];
  assign rd    = instr[11:7];

  always_comb begin
    imm       = '0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    writes_rd = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    use_imm   = 1'b0;
    alu_op    = ALU_ADD;
    res_src   = RES_ALU;
    case (instr[6:0])
      OP_REG: begin
        writes_rd = 1'b1;
        case (instr[14:12])
          3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b111:  alu_op = ALU_AND;
          3'b110:  alu_op = ALU_OR;
          default: writes_rd = 1'b0;
        endcase
      end
      OP_IMM: begin
        writes_rd = (instr[14:12] == 3'b000);
        use_imm   = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:20]};
      end
      OP_LOAD: begin
        writes_rd = 1'b1;
        mem_read  = 1'b1;
        use_imm   = 1'b1;
        res_src   = RES_MEM;
        imm       = {{20{instr[31]}}, instr[31:20]};
      end
      OP_STORE: begin
        mem_write = 1'b1;
        use_imm   = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OP_BRANCH: begin
        // only beq and bne
        is_branch = (instr[14:13] == 2'b00);
        imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OP_JAL: begin
        is_jal    = 1'b1;
        writes_rd = 1'b1;
        res_src   = RES_LINK;
        imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      OP_JALR: begin
        is_jalr   = 1'b1;
        writes_rd = 1'b1;
        res_src   = RES_LINK;
        imm       = {{20{instr[31]}}, instr[31:20]};
      end
      default: ;
    endcase
  end

  // register file with write-through of the value retiring this cycle
  always_ff @(posedge clk_i) begin
    if (mem_io.wb_reg_write) begin
      rf[mem_io.wb_rd] <= mem_io.wb_value;
    end
  end

  assign rs1_val = (rs1 == '0) ? '0 :
                   (mem_io.wb_reg_write && mem_io.wb_rd == rs1) ? mem_io.wb_value : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   (mem_io.wb_reg_write && mem_io.wb_rd == rs2) ? mem_io.wb_value : rf[rs2];

  // funct3 bit 0 separates bne from beq
  assign branch_taken = is_branch && ((rs1_val == rs2_val) != instr[12]);

  always_comb begin
    if (!ctrl_io.if_flush) begin
      pc_next = pc_q + word_t'(4);
    end else if (is_jalr) begin
      pc_next = (rs1_val + imm) & ~word_t'(1);
    end else begin
      pc_next = if_pc_q + imm;
    end
  end

  // remembers whether the instruction now in EX is a load
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_load_q <= 1'b0;
    end else if (ctrl_io.id_ex_en) begin
      ex_load_q <= ex_o.mem_read;
    end
  end

  hazard_detection_unit u_hazard (
    .mem_busy_i      (mem_io.mem_busy),
    .load_in_ex_i    (ex_load_q),
    .ex_rd_i         (ex_o.ex_rd),
    .ex_reg_write_i  (ex_o.ex_reg_write),
    .mem_rd_i        (mem_io.mem_rd),
    .mem_reg_write_i (mem_io.mem_reg_write),
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .branch_i        (is_branch),
    .branch_taken_i  (branch_taken),
    .jump_i          (is_jal),
    .ret_i           (is_jalr),
    .ctrl_o          (ctrl_io.hazard)
  );

  // writes to x0 never leave decode
  assign ex_o.valid     = if_valid_q && !ctrl_io.ctrl_zero;
  assign ex_o.reg_write = writes_rd && (rd != '0) && !ctrl_io.ctrl_zero;
  assign ex_o.mem_read  = mem_read && !ctrl_io.ctrl_zero;
  assign ex_o.mem_write = mem_write && !ctrl_io.ctrl_zero;
  assign ex_o.rs1_val   = rs1_val;
  assign ex_o.rs2_val   = rs2_val;
  assign ex_o.rs1       = rs1;
  assign ex_o.rs2       = rs2;
  assign ex_o.rd        = rd;
  assign ex_o.imm       = imm;
  assign ex_o.alu_op    = alu_op;
  assign ex_o.use_imm   = use_imm;
  assign ex_o.res_src   = res_src;
  assign ex_o.pc_plus4  = if_pc_q + word_t'(4);

  x0_never_written: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_io.wb_reg_write |-> mem_io.wb_rd != '0);

endmodule

// ==== execute_stage.sv ====
module execute_stage (
  input  logic            clk_i,
  input  logic            rst_n_i,
  id_ex_if.execute        id_i,
  ex_mem_if.execute       mem_o,
  hazard_ctrl_if.execute  ctrl_i
);

  import rv_pipe_pkg::*;

  logic      valid_q, use_imm_q, reg_write_q, mem_read_q, mem_write_q;
  word_t     rs1_val_q, rs2_val_q, imm_q, pc_plus4_q;
  reg_addr_t rs1_q, rs2_q, rd_q;
  alu_op_t   alu_op_q;
  res_src_t  res_src_q;
  word_t     op_a, op_b, alu_b;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
    end else if (ctrl_i.id_ex_en) begin
      valid_q     <= id_i.valid;
      reg_write_q <= id_i.reg_write;
      mem_read_q  <= id_i.mem_read;
      mem_write_q <= id_i.mem_write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.id_ex_en) begin
      rs1_val_q  <= id_i.rs1_val;
      rs2_val_q  <= id_i.rs2_val;
      rs1_q      <= id_i.rs1;
      rs2_q      <= id_i.rs2;
      rd_q       <= id_i.rd;
      imm_q      <= id_i.imm;
      alu_op_q   <= id_i.alu_op;
      use_imm_q  <= id_i.use_imm;
      res_src_q  <= id_i.res_src;
      pc_plus4_q <= id_i.pc_plus4;
    end else begin
      // while frozen, keep the forwarded operands so a value leaving WB is not lost
      rs1_val_q <= op_a;
      rs2_val_q <= op_b;
    end
  end

  // the EX/MEM result is newer than WB
  always_comb begin
    if (mem_o.mem_reg_write && mem_o.mem_rd == rs1_q) begin
      op_a = mem_o.mem_fwd_value;
    end else if (mem_o.wb_reg_write && mem_o.wb_rd == rs1_q) begin
      op_a = mem_o.wb_value;
    end else begin
      op_a = rs1_val_q;
    end
    if (mem_o.mem_reg_write && mem_o.mem_rd == rs2_q) begin
      op_b = mem_o.mem_fwd_value;
    end else if (mem_o.wb_reg_write && mem_o.wb_rd == rs2_q) begin
      op_b = mem_o.wb_value;
    end else begin
      op_b = rs2_val_q;
    end
  end

  assign alu_b = use_imm_q ? imm_q : op_b;

  always_comb begin
    case (alu_op_q)
      ALU_SUB: mem_o.alu_result = op_a - alu_b;
      ALU_AND: mem_o.alu_result = op_a & alu_b;
      ALU_OR:  mem_o.alu_result = op_a | alu_b;
      default: mem_o.alu_result = op_a + alu_b;
    endcase
  end

  assign mem_o.store_data = op_b;
  assign mem_o.rd         = rd_q;
  assign mem_o.reg_write  = valid_q && reg_write_q;
  assign mem_o.mem_read   = valid_q && mem_read_q;
  assign mem_o.mem_write  = valid_q && mem_write_q;
  assign mem_o.res_src    = res_src_q;
  assign mem_o.pc_plus4   = pc_plus4_q;

  assign id_i.ex_rd        = rd_q;
  assign id_i.ex_reg_write = valid_q && reg_write_q;

endmodule

// ==== result_stage.sv ====
module result_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  ex_mem_if.result               ex_i,
  hazard_ctrl_if.result          ctrl_i,
  output rv_pipe_pkg::word_t     dmem_addr_o,
  output rv_pipe_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_read_o,
  output logic                   dmem_write_o,
  input  rv_pipe_pkg::word_t     dmem_rdata_i,
  input  logic                   dmem_ready_i,
  output logic                   wb_en_o,
  output rv_pipe_pkg::reg_addr_t wb_rd_o,
  output rv_pipe_pkg::word_t     wb_data_o
);

  import rv_pipe_pkg::*;

  word_t     alu_q, store_q, pc_plus4_q, wb_value_q;
  reg_addr_t rd_q, wb_rd_q;
  logic      reg_write_q, mem_read_q, mem_write_q, wb_write_q;
  res_src_t  res_src_q;

  // EX/MEM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reg_write_q <= 1'b0;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
    end else if (ctrl_i.ex_mem_en) begin
      reg_write_q <= ex_i.reg_write;
      mem_read_q  <= ex_i.mem_read;
      mem_write_q <= ex_i.mem_write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.ex_mem_en) begin
      alu_q      <= ex_i.alu_result;
      store_q    <= ex_i.store_data;
      rd_q       <= ex_i.rd;
      res_src_q  <= ex_i.res_src;
      pc_plus4_q <= ex_i.pc_plus4;
    end
  end

  // strobes stay up until ready is seen on a clock edge
  assign dmem_addr_o  = alu_q;
  assign dmem_wdata_o = store_q;
  assign dmem_read_o  = mem_read_q;
  assign dmem_write_o = mem_write_q;

  assign ex_i.mem_busy      = (mem_read_q || mem_write_q) && !dmem_ready_i;
  assign ex_i.mem_rd        = rd_q;
  assign ex_i.mem_reg_write = reg_write_q;
  assign ex_i.mem_fwd_value = (res_src_q == RES_LINK) ? pc_plus4_q : alu_q;

  // MEM/WB
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || ctrl_i.mem_reset) begin
      wb_write_q <= 1'b0;
    end else begin
      wb_write_q <= reg_write_q;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_q <= rd_q;
    case (res_src_q)
      RES_MEM:  wb_value_q <= dmem_rdata_i;
      RES_LINK: wb_value_q <= pc_plus4_q;
      default:  wb_value_q <= alu_q;
    endcase
  end

  assign ex_i.wb_rd        = wb_rd_q;
  assign ex_i.wb_reg_write = wb_write_q;
  assign ex_i.wb_value     = wb_value_q;

  assign wb_en_o   = wb_write_q;
  assign wb_rd_o   = wb_rd_q;
  assign wb_data_o = wb_value_q;

  read_write_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dmem_read_o && dmem_write_o));

endmodule

// ==== rv_pipe_top.sv ====
module rv_pipe_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  output rv_pipe_pkg::word_t     imem_addr_o,
  input  rv_pipe_pkg::instr_t    imem_data_i,
  output rv_pipe_pkg::word_t     dmem_addr_o,
  output rv_pipe_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_read_o,
  output logic                   dmem_write_o,
  input  rv_pipe_pkg::word_t     dmem_rdata_i,
  input  logic                   dmem_ready_i,
  output logic                   wb_en_o,
  output rv_pipe_pkg::reg_addr_t wb_rd_o,
  output rv_pipe_pkg::word_t     wb_data_o
);

  hazard_ctrl_if ctrl ();
  id_ex_if       id_ex ();
  ex_mem_if      ex_mem ();

  // IF and ID, register file and hazard unit
  fetch_decode_stage u_fetch_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .ex_o        (id_ex.decode),
    .mem_io      (ex_mem.decode),
    .ctrl_io     (ctrl)
  );

  execute_stage u_execute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .id_i    (id_ex.execute),
    .mem_o   (ex_mem.execute),
    .ctrl_i  (ctrl.execute)
  );

  // MEM and WB
  result_stage u_result (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_i         (ex_mem.result),
    .ctrl_i       (ctrl.result),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_read_o  (dmem_read_o),
    .dmem_write_o (dmem_write_o),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_ready_i (dmem_ready_i),
    .wb_en_o      (wb_en_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

// ==== tb_rv_pipe_mem.sv ====
module tb_rv_pipe_mem #(
  parameter logic [31:0] SEED = 32'h0
) (
  input  logic        clk_i,
  input  logic        wait_en_i,
  input  logic [31:0] imem_addr_i,
  output logic [31:0] imem_data_o,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic        dmem_read_i,
  input  logic        dmem_write_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o
);

  logic [31:0] rom [64];
  logic [31:0] ram [64];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  integer      seed;

  initial begin
    seed         = SEED;
    dmem_ready_o = 1'b1;
  end

  // word addressed, combinational reads
  assign imem_data_o  = rom[imem_addr_i[7:2]];
  // load data is undefined unless the read strobe is up
  assign dmem_rdata_o = dmem_read_i ? ram[dmem_addr_i[7:2]] : 'x;

  // addi x0, x0, index as filler, so every slot is harmless but distinct
  task fill_rom();
    for (int i = 0; i < 64; i++) begin
      rom[i] = {12'(i), 20'h00013};
    end
  endtask

  task fill_ram();
    for (int i = 0; i < 64; i++) begin
      ram[i] = 32'hd0d0_0000 ^ 32'(i * 4);
    end
  endtask

  task clear_log();
    log_addr.delete();
    log_data.delete();
  endtask

  // ready is a free running random level when waits are enabled
  always @(posedge clk_i) begin
    integer r;
    r = $random(seed);
    dmem_ready_o <= wait_en_i ? r[0] : 1'b1;
  end

  always @(posedge clk_i) begin
    if (dmem_write_i && dmem_ready_o) begin
      ram[dmem_addr_i[7:2]] <= dmem_wdata_i;
      log_addr.push_back(dmem_addr_i);
      log_data.push_back(dmem_wdata_i);
    end
  end

endmodule

// ==== tb_rv_pipe.sv ====
module tb_rv_pipe;

  localparam int WB_TIMEOUT = 500;
  localparam int SETTLE     = 40;
  localparam logic [31:0] SEED = 32'hb500_910a;

  logic        clk;
  logic        rst_n;
  logic        wait_en;
  logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_read, dmem_write, dmem_ready, wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] prog [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [4:0]  got_rd [$];
  logic [31:0] got_data [$];
  logic        collecting;
  int          errors;

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wait_en    = 1'b0;
    collecting = 1'b0;
    errors     = 0;
  end

  always #10 clk = !clk;

  tb_rv_pipe_mem #(.SEED(SEED)) u_mem (
    .clk_i        (clk),
    .wait_en_i    (wait_en),
    .imem_addr_i  (imem_addr),
    .imem_data_o  (imem_data),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_read_i  (dmem_read),
    .dmem_write_i (dmem_write),
    .dmem_rdata_o (dmem_rdata),
    .dmem_ready_o (dmem_ready)
  );

  rv_pipe_top DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_read_o  (dmem_read),
    .dmem_write_o (dmem_write),
    .dmem_rdata_i (dmem_rdata),
    .dmem_ready_i (dmem_ready),
    .wb_en_o      (wb_en),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (collecting && wb_en) begin
      got_rd.push_back(wb_rd);
      got_data.push_back(wb_data);
    end
  end

  function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return i_word(imm, rs1, 3'b000, rd, 7'h13);
  endfunction

  task expect_wb(input logic [4:0] rd, input logic [31:0] data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task start_test();
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
  endtask

  // load program under reset, release, and gather every write-back
  task run_program(input string name, input logic waits);
    int k;
    @(posedge clk);
    rst_n   <= 1'b0;
    wait_en <= waits;
    u_mem.fill_rom();
    u_mem.fill_ram();
    u_mem.clear_log();
    for (int i = 0; i < prog.size(); i++) begin
      u_mem.rom[i] = prog[i];
    end
    got_rd.delete();
    got_data.delete();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    collecting = 1'b1;
    k = 0;
    while (got_rd.size() < exp_rd.size() && k < WB_TIMEOUT) begin
      @(posedge clk);
      k++;
    end
    if (got_rd.size() < exp_rd.size()) begin
      errors++;
      $display("%s: timed out after %0d write-backs of %0d", name, got_rd.size(),
               exp_rd.size());
    end
    // trailing window catches extra or duplicated write-backs
    repeat (SETTLE) @(posedge clk);
    collecting = 1'b0;
    if (got_rd.size() != exp_rd.size()) begin
      errors++;
      $display("%s: saw %0d write-backs where %0d were expected", name, got_rd.size(),
               exp_rd.size());
    end
    for (int i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
      if (got_rd[i] !== exp_rd[i] || got_data[i] !== exp_data[i]) begin
        errors++;
        $display("FAIL %s: write-back %0d expected x%0d=%h actual x%0d=%h", name, i,
                 exp_rd[i], exp_data[i], got_rd[i], got_data[i]);
      end
    end
  endtask

  task alu_chain_test();
    start_test();
    prog.push_back(addi(1, 0, 13));
    prog.push_back(addi(2, 1, 6));
    prog.push_back(r_word(7'h00, 2, 1, 3'b000, 3));
    prog.push_back(r_word(7'h20, 1, 3, 3'b000, 4));
    prog.push_back(r_word(7'h00, 1, 4, 3'b111, 5));
    prog.push_back(r_word(7'h00, 3, 5, 3'b110, 6));
    prog.push_back(j_word(0, 0));
    expect_wb(1, 13);
    expect_wb(2, 19);
    expect_wb(3, 32);
    expect_wb(4, 19);
    expect_wb(5, 19 & 13);
    expect_wb(6, (19 & 13) | 32);
    run_program("alu_chain", 1'b0);
  endtask

  task load_use_test();
    start_test();
    prog.push_back(addi(1, 0, 16));
    prog.push_back(i_word(0, 1, 3'b010, 2, 7'h03));
    prog.push_back(r_word(7'h00, 1, 2, 3'b000, 3));
    prog.push_back(j_word(0, 0));
    // word at byte 16 holds its preset pattern
    expect_wb(1, 16);
    expect_wb(2, 32'hd0d0_0010);
    expect_wb(3, 32'hd0d0_0010 + 16);
    run_program("load_use", 1'b0);
  endtask

  task branch_test();
    start_test();
    prog.push_back(addi(1, 0, 3));
    prog.push_back(addi(2, 0, 3));
    prog.push_back(b_word(12, 2, 1, 3'b000));
    prog.push_back(addi(3, 0, 99));
    prog.push_back(addi(3, 0, 98));
    prog.push_back(addi(4, 0, 1));
    prog.push_back(b_word(8, 1, 4, 3'b001));
    prog.push_back(addi(5, 0, 77));
    prog.push_back(b_word(8, 1, 4, 3'b000));
    prog.push_back(addi(6, 0, 2));
    prog.push_back(addi(7, 0, 3));
    prog.push_back(j_word(0, 0));
    expect_wb(1, 3);
    expect_wb(2, 3);
    expect_wb(4, 1);
    expect_wb(6, 2);
    expect_wb(7, 3);
    run_program("branch", 1'b0);
  endtask

  task jump_test();
    start_test();
    prog.push_back(j_word(12, 1));
    prog.push_back(addi(2, 0, 11));
    prog.push_back(addi(2, 0, 12));
    prog.push_back(addi(3, 0, 28));
    prog.push_back(i_word(0, 3, 3'b000, 4, 7'h67));
    prog.push_back(addi(5, 0, 55));
    prog.push_back(addi(5, 0, 66));
    prog.push_back(addi(6, 0, 7));
    prog.push_back(j_word(0, 0));
    expect_wb(1, 4);
    expect_wb(3, 28);
    expect_wb(4, 20);
    expect_wb(6, 7);
    run_program("jump", 1'b0);
  endtask

  task wait_state_test();
    start_test();
    prog.push_back(addi(1, 0, 32));
    prog.push_back(addi(2, 0, 21));
    prog.push_back(s_word(0, 2, 1));
    prog.push_back(i_word(0, 1, 3'b010, 3, 7'h03));
    prog.push_back(r_word(7'h00, 2, 3, 3'b000, 4));
    prog.push_back(s_word(4, 4, 1));
    prog.push_back(i_word(4, 1, 3'b010, 5, 7'h03));
    prog.push_back(r_word(7'h20, 1, 5, 3'b000, 6));
    prog.push_back(j_word(0, 0));
    expect_wb(1, 32);
    expect_wb(2, 21);
    expect_wb(3, 21);
    expect_wb(4, 42);
    expect_wb(5, 42);
    expect_wb(6, 10);
    // same program and expected list run without and then with wait states
    run_program("no_wait", 1'b0);
    run_program("random_wait", 1'b1);
  endtask

  task store_load_test();
    start_test();
    prog.push_back(addi(1, 0, 40));
    prog.push_back(addi(2, 0, 12'h5a5));
    prog.push_back(s_word(0, 2, 1));
    prog.push_back(i_word(0, 1, 3'b010, 3, 7'h03));
    prog.push_back(j_word(0, 0));
    expect_wb(1, 40);
    expect_wb(2, 32'h5a5);
    expect_wb(3, 32'h5a5);
    run_program("store_load", 1'b1);
    if (u_mem.log_addr.size() != 1) begin
      errors++;
      $display("store_load: memory saw %0d writes instead of one", u_mem.log_addr.size());
    end else begin
      if (u_mem.log_addr[0] !== 32'd40) begin
        errors++;
        $display("FAIL store_load: write address expected %h actual %h", 32'd40,
                 u_mem.log_addr[0]);
      end
      if (u_mem.log_data[0] !== 32'h5a5) begin
        errors++;
        $display("FAIL store_load: write data expected %h actual %h", 32'h5a5,
                 u_mem.log_data[0]);
      end
    end
  endtask

  initial begin
    alu_chain_test();
    load_use_test();
    branch_test();
    jump_test();
    wait_state_test();
    store_load_test();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== rv_pipe.f ====
+incdir+.
rv_pipe_pkg.sv
rv_pipe_if.sv
hazard_detection_unit.sv
fetch_decode_stage.sv
execute_stage.sv
result_stage.sv
rv_pipe_top.sv
tb_rv_pipe_mem.sv
tb_rv_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_rv_pipe
FILELIST  := rv_pipe.f
PASS_MSG  := Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST)) rv_pipe_settings.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
